/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_flip_subsystem
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST)) common/flip_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Done: errors found" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/flip_params.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip loop sizes
// Spin width, slot count, energy width and icon memory depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FLIP_PARAMS_SVH
`define FLIP_PARAMS_SVH

// Spins per vector
`define FLIP_NUM_SPIN 16
// Spin slots held by the loop
`define FLIP_SPIN_DEPTH 2
// Signed energy width
`define FLIP_ENERGY_BIT 16
// Icon memory words and address width
`define FLIP_ICON_DEPTH 8
`define FLIP_ICON_ADDR_BIT 3

`endif

/* common/flip_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip loop types
// Spin, energy, icon address and slot index types with derived sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "flip_params.svh"

package flip_pkg;

    localparam int SPIN_DEPTH = `FLIP_SPIN_DEPTH;
    localparam int ICON_DEPTH = `FLIP_ICON_DEPTH;
    localparam int ICON_ADDR_BIT = `FLIP_ICON_ADDR_BIT;
    // Slot index keeps at least one bit
    localparam int SLOT_BIT = (`FLIP_SPIN_DEPTH > 1) ? $clog2(`FLIP_SPIN_DEPTH) : 1;

    typedef logic [`FLIP_NUM_SPIN-1:0] spin_t;
    typedef logic signed [`FLIP_ENERGY_BIT-1:0] energy_t;
    // Extra bit lets the address reach the list end
    typedef logic [ICON_ADDR_BIT:0] icon_addr_t;
    typedef logic [SLOT_BIT-1:0] slot_t;

    localparam slot_t SLOT_LAST = slot_t'(`FLIP_SPIN_DEPTH - 1);
    localparam logic [SLOT_BIT:0] SLOT_COUNT = (SLOT_BIT + 1)'(`FLIP_SPIN_DEPTH);
    // Largest positive energy
    localparam energy_t ENERGY_MAX = {1'b0, {(`FLIP_ENERGY_BIT-1){1'b1}}};

endpackage

`default_nettype wire

/* flip_manager/energy_fifo_maintainer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Energy maintainer
// Keeps the best energy per slot and decides keep or replace per result
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module energy_fifo_maintainer (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              en_i,
    input  logic              flush_i,
    input  logic              en_comparison_i,
    input  logic              energy_take_i,
    input  logic              energy_valid_i,
    output logic              energy_ready_o,
    input  flip_pkg::energy_t energy_i,
    input  flip_pkg::spin_t   spin_i,
    output logic              spin_valid_o,
    output flip_pkg::spin_t   spin_o,
    output logic              spin_push_none_o,
    input  logic              spin_ready_i
);
    flip_pkg::energy_t best_energy [flip_pkg::SPIN_DEPTH];
    flip_pkg::slot_t   slot_ptr;
    logic              energy_hs;
    logic              replace;

    // One-entry output register
    assign energy_ready_o = ~spin_valid_o | spin_ready_i;
    assign energy_hs = energy_valid_i & energy_ready_o & energy_take_i;
    // Only a strictly lower energy wins while comparing
    assign replace = ~en_comparison_i | (energy_i < best_energy[slot_ptr]);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_ptr <= '0;
            spin_valid_o <= 1'b0;
            spin_push_none_o <= 1'b0;
            for (int i = 0; i < flip_pkg::SPIN_DEPTH; i++) begin
                best_energy[i] <= flip_pkg::ENERGY_MAX;
            end
        end else if (en_i) begin
            if (flush_i) begin
                slot_ptr <= '0;
                spin_valid_o <= 1'b0;
                spin_push_none_o <= 1'b0;
                for (int i = 0; i < flip_pkg::SPIN_DEPTH; i++) begin
                    best_energy[i] <= flip_pkg::ENERGY_MAX;
                end
            end else if (energy_hs) begin
                spin_valid_o <= 1'b1;
                spin_push_none_o <= ~replace;
                slot_ptr <= (slot_ptr == flip_pkg::SLOT_LAST) ? '0 : slot_ptr + 1'b1;
                if (replace) begin
                    best_energy[slot_ptr] <= energy_i;
                end
            end else if (spin_ready_i) begin
                spin_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && energy_hs) begin
            spin_o <= spin_i;
        end
    end

endmodule

`default_nettype wire

/* flip_manager/flip_engine.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip engine
// XORs popped spins with icon words and walks the icon address list
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module flip_engine (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 flush_i,
    input  logic                 cmpt_busy_i,
    input  logic                 flip_disable_i,
    input  logic                 prev_spin_valid_i,
    input  flip_pkg::spin_t      prev_spin_i,
    output logic                 prev_spin_ready_o,
    output logic                 flipped_spin_valid_o,
    output flip_pkg::spin_t      flipped_spin_o,
    input  logic                 flipped_spin_ready_i,
    output logic                 flip_ren_o,
    output flip_pkg::icon_addr_t flip_raddr_o,
    input  flip_pkg::spin_t      flip_rdata_i,
    input  flip_pkg::icon_addr_t icon_last_raddr_plus_one_i,
    output logic                 icon_finish_o
);
    flip_pkg::icon_addr_t raddr;
    flip_pkg::spin_t      stage_spin;
    logic                 stage_flip;
    logic                 stage_valid;
    logic                 accept;
    logic                 flip_now;

    assign icon_finish_o = cmpt_busy_i & (raddr == icon_last_raddr_plus_one_i);
    // Take a spin only when the stage is sure to move on next cycle
    assign prev_spin_ready_o = ~stage_valid & ~icon_finish_o
                               & (~flipped_spin_valid_o | flipped_spin_ready_i);
    assign accept = prev_spin_valid_i & prev_spin_ready_o;
    assign flip_now = cmpt_busy_i & ~flip_disable_i;
    assign flip_ren_o = accept & flip_now & en_i;
    assign flip_raddr_o = raddr;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_valid <= 1'b0;
            flipped_spin_valid_o <= 1'b0;
            raddr <= '0;
        end else if (en_i) begin
            if (flush_i) begin
                stage_valid <= 1'b0;
                flipped_spin_valid_o <= 1'b0;
                raddr <= '0;
            end else begin
                stage_valid <= accept;
                if (stage_valid) begin
                    flipped_spin_valid_o <= 1'b1;
                end else if (flipped_spin_ready_i) begin
                    flipped_spin_valid_o <= 1'b0;
                end
                if (icon_finish_o) begin
                    raddr <= '0;
                end else if (accept && flip_now) begin
                    raddr <= raddr + 1'b1;
                end
            end
        end
    end

    // Icon word arrives while the spin waits in the stage
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (accept) begin
                stage_spin <= prev_spin_i;
                stage_flip <= flip_now;
            end
            if (stage_valid) begin
                flipped_spin_o <= stage_flip ? (stage_spin ^ flip_rdata_i) : stage_spin;
            end
        end
    end

endmodule

`default_nettype wire

/* flip_manager/flip_manager.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip manager
// Routes spin store pushes from host or energy path, runs the flip loop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module flip_manager (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 flush_i,
    input  logic                 en_comparison_i,
    input  logic                 cmpt_en_i,
    output logic                 cmpt_idle_o,
    input  logic                 host_readout_i,
    input  logic                 flip_disable_i,
    input  logic                 spin_configure_valid_i,
    input  flip_pkg::spin_t      spin_configure_i,
    input  logic                 spin_configure_push_none_i,
    output logic                 spin_configure_ready_o,
    output logic                 spin_pop_valid_o,
    output flip_pkg::spin_t      spin_pop_o,
    input  logic                 spin_pop_ready_i,
    input  logic                 energy_valid_i,
    output logic                 energy_ready_o,
    input  flip_pkg::energy_t    energy_i,
    input  flip_pkg::spin_t      spin_i,
    output logic                 flip_ren_o,
    output flip_pkg::icon_addr_t flip_raddr_o,
    input  flip_pkg::spin_t      flip_rdata_i,
    input  flip_pkg::icon_addr_t icon_last_raddr_plus_one_i,
    output logic                 energy_fifo_update_o,
    output logic                 spin_fifo_update_o
);
    logic            cmpt_busy;
    logic            icon_finish;
    logic            push_valid;
    flip_pkg::spin_t push_spin;
    logic            push_none;
    logic            push_ready;
    logic            result_valid;
    flip_pkg::spin_t result_spin;
    logic            result_none;
    logic            store_pop_valid;
    flip_pkg::spin_t store_pop;
    logic            store_pop_ready;
    logic            energy_hs;
    logic            push_hs;

    assign cmpt_idle_o = ~cmpt_busy;
    assign spin_configure_ready_o = push_ready & cmpt_idle_o;

    // Energy results own the store while a run is busy
    assign push_valid = cmpt_busy ? result_valid : spin_configure_valid_i;
    assign push_spin = cmpt_busy ? result_spin : spin_configure_i;
    assign push_none = cmpt_busy ? result_none : spin_configure_push_none_i;

    assign energy_hs = energy_valid_i & energy_ready_o & cmpt_busy;
    assign push_hs = push_valid & push_ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            energy_fifo_update_o <= 1'b0;
            spin_fifo_update_o <= 1'b0;
        end else if (en_i) begin
            energy_fifo_update_o <= energy_hs & ~flush_i;
            spin_fifo_update_o <= push_hs & ~flush_i;
        end
    end

    energy_fifo_maintainer energy_fifo_maintainer_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .en_i             (en_i),
        .flush_i          (flush_i),
        .en_comparison_i  (en_comparison_i),
        .energy_take_i    (cmpt_busy),
        .energy_valid_i   (energy_valid_i),
        .energy_ready_o   (energy_ready_o),
        .energy_i         (energy_i),
        .spin_i           (spin_i),
        .spin_valid_o     (result_valid),
        .spin_o           (result_spin),
        .spin_push_none_o (result_none),
        .spin_ready_i     (push_ready & cmpt_busy)
    );

    spin_fifo_maintainer spin_fifo_maintainer_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .en_i              (en_i),
        .flush_i           (flush_i),
        .cmpt_en_i         (cmpt_en_i),
        .icon_finish_i     (icon_finish),
        .host_readout_i    (host_readout_i),
        .spin_push_valid_i (push_valid),
        .spin_push_i       (push_spin),
        .spin_push_none_i  (push_none),
        .spin_push_ready_o (push_ready),
        .spin_pop_valid_o  (store_pop_valid),
        .spin_pop_o        (store_pop),
        .spin_pop_ready_i  (store_pop_ready),
        .cmpt_busy_o       (cmpt_busy)
    );

    flip_engine flip_engine_i (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .en_i                       (en_i),
        .flush_i                    (flush_i),
        .cmpt_busy_i                (cmpt_busy),
        .flip_disable_i             (flip_disable_i),
        .prev_spin_valid_i          (store_pop_valid),
        .prev_spin_i                (store_pop),
        .prev_spin_ready_o          (store_pop_ready),
        .flipped_spin_valid_o       (spin_pop_valid_o),
        .flipped_spin_o             (spin_pop_o),
        .flipped_spin_ready_i       (spin_pop_ready_i),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .flip_rdata_i               (flip_rdata_i),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .icon_finish_o              (icon_finish)
    );

endmodule

`default_nettype wire

/* flip_manager/spin_fifo_maintainer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Spin store
// Circular slot store with occupancy count and compute run control
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module spin_fifo_maintainer (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            en_i,
    input  logic            flush_i,
    input  logic            cmpt_en_i,
    input  logic            icon_finish_i,
    input  logic            host_readout_i,
    input  logic            spin_push_valid_i,
    input  flip_pkg::spin_t spin_push_i,
    input  logic            spin_push_none_i,
    output logic            spin_push_ready_o,
    output logic            spin_pop_valid_o,
    output flip_pkg::spin_t spin_pop_o,
    input  logic            spin_pop_ready_i,
    output logic            cmpt_busy_o
);
    flip_pkg::spin_t             slots [flip_pkg::SPIN_DEPTH];
    flip_pkg::slot_t             wptr;
    flip_pkg::slot_t             rptr;
    logic [flip_pkg::SLOT_BIT:0] count;
    logic                        full;
    logic                        stop;
    logic                        push_hs;
    logic                        pop_hs;

    assign full = (count == flip_pkg::SLOT_COUNT);
    assign spin_push_ready_o = ~full;
    assign push_hs = spin_push_valid_i & spin_push_ready_o;
    // Pops pause after the icon list ends so the store can fill again
    assign spin_pop_valid_o = (count != '0) & ((cmpt_busy_o & ~stop) | host_readout_i);
    assign spin_pop_o = slots[rptr];
    assign pop_hs = spin_pop_valid_o & spin_pop_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
            cmpt_busy_o <= 1'b0;
            stop <= 1'b0;
        end else if (en_i) begin
            if (flush_i) begin
                wptr <= '0;
                rptr <= '0;
                count <= '0;
                cmpt_busy_o <= 1'b0;
                stop <= 1'b0;
            end else begin
                if (push_hs) begin
                    wptr <= (wptr == flip_pkg::SLOT_LAST) ? '0 : wptr + 1'b1;
                end
                if (pop_hs) begin
                    rptr <= (rptr == flip_pkg::SLOT_LAST) ? '0 : rptr + 1'b1;
                end
                if (push_hs && !pop_hs) begin
                    count <= count + 1'b1;
                end else if (pop_hs && !push_hs) begin
                    count <= count - 1'b1;
                end
                // Run starts from a full store and ends once it is full again
                if (!cmpt_busy_o) begin
                    cmpt_busy_o <= cmpt_en_i & full;
                end else if (stop && full) begin
                    cmpt_busy_o <= 1'b0;
                    stop <= 1'b0;
                end else if (icon_finish_i) begin
                    stop <= 1'b1;
                end
            end
        end
    end

    // push_none keeps the old slot contents
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (flush_i) begin
                for (int i = 0; i < flip_pkg::SPIN_DEPTH; i++) begin
                    slots[i] <= '0;
                end
            end else if (push_hs && !spin_push_none_i) begin
                slots[wptr] <= spin_push_i;
            end
        end
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/flip_pkg.sv
flip_manager/energy_fifo_maintainer.sv
flip_manager/spin_fifo_maintainer.sv
flip_manager/flip_engine.sv
flip_manager/flip_manager.sv
source/flip_icon_memory.sv
source/flip_subsystem.sv
testbench/tb_flip_subsystem.sv

/* source/flip_icon_memory.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Icon memory
// Host-written flip icon RAM with registered read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module flip_icon_memory (
    input  logic                 clk_i,
    input  logic                 icon_we_i,
    input  flip_pkg::icon_addr_t icon_waddr_i,
    input  flip_pkg::spin_t      icon_wdata_i,
    input  logic                 flip_ren_i,
    input  flip_pkg::icon_addr_t flip_raddr_i,
    output flip_pkg::spin_t      flip_rdata_o
);
    flip_pkg::spin_t icons [flip_pkg::ICON_DEPTH];

    // Top address bit only marks the list end
    always_ff @(posedge clk_i) begin
        if (icon_we_i) begin
            icons[icon_waddr_i[flip_pkg::ICON_ADDR_BIT-1:0]] <= icon_wdata_i;
        end
        if (flip_ren_i) begin
            flip_rdata_o <= icons[flip_raddr_i[flip_pkg::ICON_ADDR_BIT-1:0]];
        end
    end

endmodule

`default_nettype wire

/* source/flip_subsystem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip subsystem
// Spin-update loop of the annealer with its flip icon memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module flip_subsystem (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 flush_i,
    input  logic                 en_comparison_i,
    input  logic                 cmpt_en_i,
    output logic                 cmpt_idle_o,
    input  logic                 host_readout_i,
    input  logic                 flip_disable_i,
    input  logic                 spin_configure_valid_i,
    input  flip_pkg::spin_t      spin_configure_i,
    input  logic                 spin_configure_push_none_i,
    output logic                 spin_configure_ready_o,
    output logic                 spin_pop_valid_o,
    output flip_pkg::spin_t      spin_pop_o,
    input  logic                 spin_pop_ready_i,
    input  logic                 energy_valid_i,
    output logic                 energy_ready_o,
    input  flip_pkg::energy_t    energy_i,
    input  flip_pkg::spin_t      spin_i,
    input  logic                 icon_we_i,
    input  flip_pkg::icon_addr_t icon_waddr_i,
    input  flip_pkg::spin_t      icon_wdata_i,
    input  flip_pkg::icon_addr_t icon_last_raddr_plus_one_i,
    output logic                 energy_fifo_update_o,
    output logic                 spin_fifo_update_o
);
    logic                 flip_ren;
    flip_pkg::icon_addr_t flip_raddr;
    flip_pkg::spin_t      flip_rdata;

    flip_manager flip_manager_i (
        .clk_i                      (clk_i),
        .rst_n_i                    (rst_n_i),
        .en_i                       (en_i),
        .flush_i                    (flush_i),
        .en_comparison_i            (en_comparison_i),
        .cmpt_en_i                  (cmpt_en_i),
        .cmpt_idle_o                (cmpt_idle_o),
        .host_readout_i             (host_readout_i),
        .flip_disable_i             (flip_disable_i),
        .spin_configure_valid_i     (spin_configure_valid_i),
        .spin_configure_i           (spin_configure_i),
        .spin_configure_push_none_i (spin_configure_push_none_i),
        .spin_configure_ready_o     (spin_configure_ready_o),
        .spin_pop_valid_o           (spin_pop_valid_o),
        .spin_pop_o                 (spin_pop_o),
        .spin_pop_ready_i           (spin_pop_ready_i),
        .energy_valid_i             (energy_valid_i),
        .energy_ready_o             (energy_ready_o),
        .energy_i                   (energy_i),
        .spin_i                     (spin_i),
        .flip_ren_o                 (flip_ren),
        .flip_raddr_o               (flip_raddr),
        .flip_rdata_i               (flip_rdata),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .energy_fifo_update_o       (energy_fifo_update_o),
        .spin_fifo_update_o         (spin_fifo_update_o)
    );

    flip_icon_memory flip_icon_memory_i (
        .clk_i        (clk_i),
        .icon_we_i    (icon_we_i),
        .icon_waddr_i (icon_waddr_i),
        .icon_wdata_i (icon_wdata_i),
        .flip_ren_i   (flip_ren),
        .flip_raddr_i (flip_raddr),
        .flip_rdata_o (flip_rdata)
    );

endmodule

`default_nettype wire

/* testbench/tb_flip_subsystem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip subsystem testbench
// Host and energy calculator stimulus against a reference model of the loop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "flip_params.svh"

module tb_flip_subsystem;

    localparam int RUN_POPS = 5;
    localparam int WATCHDOG_CYCLES = 4000;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 en_i;
    logic                 flush_i;
    logic                 en_comparison_i;
    logic                 cmpt_en_i;
    logic                 cmpt_idle_o;
    logic                 host_readout_i;
    logic                 flip_disable_i;
    logic                 spin_configure_valid_i;
    flip_pkg::spin_t      spin_configure_i;
    logic                 spin_configure_push_none_i;
    logic                 spin_configure_ready_o;
    logic                 spin_pop_valid_o;
    flip_pkg::spin_t      spin_pop_o;
    logic                 spin_pop_ready_i;
    logic                 energy_valid_i;
    logic                 energy_ready_o;
    flip_pkg::energy_t    energy_i;
    flip_pkg::spin_t      spin_i;
    logic                 icon_we_i;
    flip_pkg::icon_addr_t icon_waddr_i;
    flip_pkg::spin_t      icon_wdata_i;
    flip_pkg::icon_addr_t icon_last_raddr_plus_one_i;
    logic                 energy_fifo_update_o;
    logic                 spin_fifo_update_o;

    integer seed = 32'hda40_f593;
    int value_errors = 0;
    int protocol_errors = 0;
    int spin_updates = 0;
    int energy_updates = 0;

    // Reference model of slots, icons and best energies
    flip_pkg::spin_t   ref_slot [flip_pkg::SPIN_DEPTH];
    flip_pkg::energy_t ref_best [flip_pkg::SPIN_DEPTH];
    flip_pkg::spin_t   ref_icon [`FLIP_ICON_DEPTH];
    int ref_wptr;
    int ref_rptr;
    int ref_eptr;
    int ref_addr;

    flip_subsystem flip_subsystem_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    always @(posedge clk_i) begin
        if (spin_fifo_update_o) spin_updates++;
        if (energy_fifo_update_o) energy_updates++;
    end

    // Held pop output must not move until it is taken
    pop_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (spin_pop_valid_o && !spin_pop_ready_i && !flush_i)
        |=> (spin_pop_valid_o && $stable(spin_pop_o)))
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: pop output changed under back-pressure", $time);
    end

    cfg_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !cmpt_idle_o |-> !spin_configure_ready_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: configure ready high while busy", $time);
    end

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h",
                     $time, what, got, expected);
        end
    endtask

    // Calculator energy is the popcount plus a per-slot bias
    function automatic flip_pkg::energy_t energy_of(flip_pkg::spin_t s,
                                                    flip_pkg::energy_t bias);
        return flip_pkg::energy_t'($countones(s)) + bias;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < flip_pkg::SPIN_DEPTH; i++) begin
            ref_slot[i] = '0;
            ref_best[i] = {1'b0, {(`FLIP_ENERGY_BIT-1){1'b1}}};
        end
        ref_wptr = 0;
        ref_rptr = 0;
        ref_eptr = 0;
        ref_addr = 0;
    endtask

    // All tasks start and end 1 ns after a rising edge
    task automatic push_config(input flip_pkg::spin_t s, input logic none);
        spin_configure_valid_i = 1'b1;
        spin_configure_i = s;
        spin_configure_push_none_i = none;
        @(posedge clk_i);
        while (!spin_configure_ready_o) @(posedge clk_i);
        #1 spin_configure_valid_i = 1'b0;
        if (!none) ref_slot[ref_wptr] = s;
        ref_wptr = (ref_wptr + 1) % flip_pkg::SPIN_DEPTH;
    endtask

    task automatic take_pop(input int hold, output flip_pkg::spin_t s);
        spin_pop_ready_i = (hold == 0);
        @(posedge clk_i);
        while (!spin_pop_valid_o) @(posedge clk_i);
        if (hold > 0) begin
            repeat (hold) @(posedge clk_i);
            #1 spin_pop_ready_i = 1'b1;
            @(posedge clk_i);
        end
        s = spin_pop_o;
        #1 spin_pop_ready_i = 1'b0;
    endtask

    task automatic return_energy(input flip_pkg::energy_t e, input flip_pkg::spin_t s);
        energy_valid_i = 1'b1;
        energy_i = e;
        spin_i = s;
        @(posedge clk_i);
        while (!energy_ready_o) @(posedge clk_i);
        #1 energy_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk_i);
        while (!cmpt_idle_o) @(posedge clk_i);
        #1;
    endtask

    task automatic start_run();
        cmpt_en_i = 1'b1;
        @(posedge clk_i);
        #1 cmpt_en_i = 1'b0;
        @(posedge clk_i);
        expect_equal("idle after start", cmpt_idle_o, 0);
        #1;
    endtask

    task automatic apply_flush();
        flush_i = 1'b1;
        @(posedge clk_i);
        #1 flush_i = 1'b0;
        @(posedge clk_i);
        expect_equal("idle after flush", cmpt_idle_o, 1);
        expect_equal("pop valid after flush", spin_pop_valid_o, 0);
        #1;
        clear_model();
    endtask

    task automatic readout_check();
        flip_pkg::spin_t got;
        host_readout_i = 1'b1;
        for (int k = 0; k < flip_pkg::SPIN_DEPTH; k++) begin
            take_pop(0, got);
            expect_equal("readout spin", got, ref_slot[ref_rptr]);
            ref_rptr = (ref_rptr + 1) % flip_pkg::SPIN_DEPTH;
        end
        host_readout_i = 1'b0;
    endtask

    // One full run of icon flips; hold_at picks a pop to stall
    task automatic compute_run(input flip_pkg::energy_t bias0, input flip_pkg::energy_t bias1,
                               input int hold_at);
        flip_pkg::spin_t   expected;
        flip_pkg::spin_t   got;
        flip_pkg::energy_t bias;
        flip_pkg::energy_t e;
        int                energy_before;
        int                spin_before;
        energy_before = energy_updates;
        spin_before = spin_updates;
        for (int k = 0; k < RUN_POPS; k++) begin
            expected = ref_slot[ref_rptr] ^ ref_icon[ref_addr];
            ref_rptr = (ref_rptr + 1) % flip_pkg::SPIN_DEPTH;
            ref_addr = (ref_addr + 1) % RUN_POPS;
            bias = (ref_eptr == 0) ? bias0 : bias1;
            take_pop((k == hold_at) ? 3 : 0, got);
            expect_equal("flipped spin", got, expected);
            return_energy(energy_of(got, bias), got);
            e = energy_of(expected, bias);
            if (!en_comparison_i || e < ref_best[ref_eptr]) begin
                ref_best[ref_eptr] = e;
                ref_slot[ref_wptr] = expected;
            end
            ref_eptr = (ref_eptr + 1) % flip_pkg::SPIN_DEPTH;
            ref_wptr = (ref_wptr + 1) % flip_pkg::SPIN_DEPTH;
        end
        wait_idle();
        repeat (2) @(posedge clk_i);
        #1;
        expect_equal("energy updates per run", energy_updates - energy_before, RUN_POPS);
        expect_equal("spin updates per run", spin_updates - spin_before, RUN_POPS);
    endtask

    initial begin
        flip_pkg::spin_t got;
        int              updates_before;
        rst_n_i = 1'b0;
        en_i = 1'b1;
        flush_i = 1'b0;
        en_comparison_i = 1'b0;
        cmpt_en_i = 1'b0;
        host_readout_i = 1'b0;
        flip_disable_i = 1'b0;
        spin_configure_valid_i = 1'b0;
        spin_configure_i = '0;
        spin_configure_push_none_i = 1'b0;
        spin_pop_ready_i = 1'b0;
        energy_valid_i = 1'b0;
        energy_i = '0;
        spin_i = '0;
        icon_we_i = 1'b0;
        icon_waddr_i = '0;
        icon_wdata_i = '0;
        icon_last_raddr_plus_one_i = flip_pkg::icon_addr_t'(RUN_POPS);
        clear_model();
        repeat (8) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        @(posedge clk_i);
        expect_equal("idle after reset", cmpt_idle_o, 1);
        expect_equal("energy ready after reset", energy_ready_o, 1);
        expect_equal("pop valid after reset", spin_pop_valid_o, 0);
        expect_equal("energy update after reset", energy_fifo_update_o, 0);
        expect_equal("spin update after reset", spin_fifo_update_o, 0);
        #1;
        for (int a = 0; a < `FLIP_ICON_DEPTH; a++) begin
            ref_icon[a] = flip_pkg::spin_t'($random(seed));
            icon_we_i = 1'b1;
            icon_waddr_i = flip_pkg::icon_addr_t'(a);
            icon_wdata_i = ref_icon[a];
            @(posedge clk_i);
            #1;
        end
        icon_we_i = 1'b0;

        // Configure and read back, first slot left at its flushed value
        apply_flush();
        flip_disable_i = 1'b1;
        updates_before = spin_updates;
        push_config(flip_pkg::spin_t'($random(seed)), 1'b1);
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        readout_check();
        repeat (2) @(posedge clk_i);
        #1;
        expect_equal("spin updates for configure", spin_updates - updates_before, 2);

        flip_disable_i = 1'b0;
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        start_run();
        compute_run(16'sd0, 16'sd0, 1);

        // Slot 1 results are forced high and must be rejected
        en_comparison_i = 1'b1;
        start_run();
        compute_run(-16'sd20, 16'sh7000, -1);
        flip_disable_i = 1'b1;
        readout_check();

        // Flush in the middle of a run
        flip_disable_i = 1'b0;
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        start_run();
        take_pop(0, got);
        return_energy(energy_of(got, 16'sd0), got);
        // Second flipped spin waits under back-pressure when the flush hits
        @(posedge clk_i);
        while (!spin_pop_valid_o) @(posedge clk_i);
        #1;
        apply_flush();
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        push_config(flip_pkg::spin_t'($random(seed)), 1'b0);
        start_run();
        compute_run(16'sh7000, 16'sh7000, -1);
        flip_disable_i = 1'b1;
        readout_check();

        repeat (2) @(posedge clk_i);
        $display("Error counts: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
